// ==== hw/fe_pkg.sv ====
package fe_pkg;

  localparam int XLEN        = 32;
  localparam int FETCH_WIDTH = 2;
  localparam int MEM_ROWS    = 16;
  localparam int MEM_ROW_W   = $clog2(MEM_ROWS);
  localparam int FIFO_DEPTH  = 8;
  localparam int FIFO_AW     = $clog2(FIFO_DEPTH);

  localparam string MEM_FILE = "hw/program.hex";

  // rv32i major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef enum logic [2:0] {
    OP_ALU    = 3'd0,
    OP_LOAD   = 3'd1,
    OP_STORE  = 3'd2,
    OP_BRANCH = 3'd3,
    OP_SYSTEM = 3'd4,
    OP_NONE   = 3'd5
  } fe_op_e;

  // mask bit 0 is slot 0
  typedef struct packed {
    logic [XLEN-1:0]        pc;
    logic [FETCH_WIDTH-1:0] mask;
  } fe_pc_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0]                  pc;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] inst;
    logic [FETCH_WIDTH-1:0]           mask;
  } fe_fetch_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    fe_op_e          op;
    logic            illegal;
  } fe_dec_slot_t;

  typedef struct packed {
    fe_dec_slot_t [FETCH_WIDTH-1:0] slot;
    logic [FETCH_WIDTH-1:0]         mask;
  } fe_dec_pkt_t;

endpackage

// ==== hw/fe_skid_buf.sv ====
`timescale 1ns/1ps

module fe_skid_buf #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  logic flush_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  logic ready_q;
  T     data_q;

  // low ready means data_q holds a beat
  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
      ready_q <= 1'b1;
    else if (ready_q)
      ready_q <= !(in_valid_i && !out_ready_i);
    else
      ready_q <= out_ready_i;
  end

  always_ff @(posedge clk)
  begin
    if (ready_q)
      data_q <= in_data_i;
  end

  assign in_ready_o  = ready_q;
  assign out_valid_o = in_valid_i || !ready_q;
  assign out_data_o  = ready_q ? in_data_i : data_q;

endmodule

// ==== hw/fe_pc_gen.sv ====
`timescale 1ns/1ps

module fe_pc_gen import fe_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  logic [XLEN-1:0]        redirect_pc_i,
  output logic                   valid_o,
  input  logic                   ready_i,
  output logic [XLEN-1:0]        pc_o,
  output logic [FETCH_WIDTH-1:0] mask_o
);

  logic [XLEN-1:0] pc_q;
  logic            valid_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pc_q    <= '0;
      valid_q <= 1'b0;
    end
    else if (flush_i)
    begin
      // word aligned, bit 2 kept for the first block
      pc_q    <= {redirect_pc_i[XLEN-1:2], 2'b00};
      valid_q <= 1'b1;
    end
    else
    begin
      valid_q <= 1'b1;
      if (valid_q && ready_i)
        pc_q <= {pc_q[XLEN-1:3] + 1'b1, 3'b000};
    end
  end

  assign valid_o = valid_q;
  assign pc_o    = pc_q;
  // upper word only when entered mid-block
  assign mask_o  = {1'b1, !pc_q[2]};

endmodule

// ==== hw/fe_inst_mem.sv ====
`timescale 1ns/1ps

module fe_inst_mem import fe_pkg::*; (
  input  logic                             clk,
  input  logic                             rd_en_i,
  input  logic [MEM_ROW_W-1:0]             rd_row_i,
  output logic [FETCH_WIDTH-1:0][XLEN-1:0] rd_data_o
);

  // word image, two consecutive words form one row
  logic [XLEN-1:0] words [MEM_ROWS*FETCH_WIDTH];

  initial
  begin
    $readmemh(MEM_FILE, words);
  end

  // output holds between reads
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      for (int i = 0; i < FETCH_WIDTH; i++)
      begin
        rd_data_o[i] <= words[int'(rd_row_i) * FETCH_WIDTH + i];
      end
    end
  end

endmodule

// ==== hw/fe_fetch.sv ====
`timescale 1ns/1ps

module fe_fetch import fe_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             flush_i,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  input  logic [XLEN-1:0]                  in_pc_i,
  input  logic [FETCH_WIDTH-1:0]           in_mask_i,
  output logic                             mem_en_o,
  output logic [MEM_ROW_W-1:0]             mem_row_o,
  input  logic [FETCH_WIDTH-1:0][XLEN-1:0] mem_data_i,
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output logic [XLEN-1:0]                  out_pc_o,
  output logic [FETCH_WIDTH-1:0][XLEN-1:0] out_inst_o,
  output logic [FETCH_WIDTH-1:0]           out_mask_o
);

  logic                             busy_q;
  logic                             fresh_q;
  logic                             accept;
  logic [XLEN-1:0]                  pc_q;
  logic [FETCH_WIDTH-1:0]           mask_q;
  logic [FETCH_WIDTH-1:0][XLEN-1:0] row_q;
  logic [FETCH_WIDTH-1:0][XLEN-1:0] row;

  assign in_ready_o = !busy_q || out_ready_i;
  assign accept     = in_valid_i && in_ready_o && !flush_i;
  assign mem_en_o   = accept;
  assign mem_row_o  = in_pc_i[MEM_ROW_W+2:3];

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      busy_q  <= 1'b0;
      fresh_q <= 1'b0;
    end
    else
    begin
      fresh_q <= accept;
      if (in_ready_o)
        busy_q <= accept;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      pc_q   <= in_pc_i;
      mask_q <= in_mask_i;
    end
    // capture on the return cycle, stalls then read the copy
    if (fresh_q)
      row_q <= mem_data_i;
  end

  assign row = fresh_q ? mem_data_i : row_q;

  always_comb
  begin
    out_inst_o = row;
    out_mask_o = mask_q;
    if (!mask_q[0])
    begin
      out_inst_o[0] = row[1];
      out_mask_o    = {1'b0, mask_q[1]};
    end
  end

  // pc bit 2 already points at the first valid word
  assign out_pc_o    = pc_q;
  assign out_valid_o = busy_q;

endmodule

// ==== hw/fe_decoder.sv ====
`timescale 1ns/1ps

module fe_decoder import fe_pkg::*; (
  input  logic [XLEN-1:0] inst_i,
  output fe_op_e          op_o,
  output logic            illegal_o
);

  always_comb
  begin
    op_o = OP_NONE;
    // compressed or reserved encodings stay illegal
    if (inst_i[1:0] == 2'b11)
    begin
      case (inst_i[6:0])
        OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC:
          op_o = OP_ALU;
        OPC_LOAD:
          op_o = OP_LOAD;
        OPC_STORE:
          op_o = OP_STORE;
        OPC_BRANCH, OPC_JAL, OPC_JALR:
          op_o = OP_BRANCH;
        OPC_SYSTEM:
          op_o = OP_SYSTEM;
        default:
          op_o = OP_NONE;
      endcase
    end
  end

  assign illegal_o = (op_o == OP_NONE);

endmodule

// ==== hw/fe_decode_stage.sv ====
`timescale 1ns/1ps

module fe_decode_stage import fe_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          flush_i,
  input  logic          in_valid_i,
  output logic          in_ready_o,
  input  fe_fetch_pkt_t in_data_i,
  output logic          out_valid_o,
  input  logic          out_ready_i,
  output fe_dec_pkt_t   out_data_o
);

  logic                     valid_q;
  fe_fetch_pkt_t            pkt_q;
  fe_op_e [FETCH_WIDTH-1:0] op;
  logic [FETCH_WIDTH-1:0]   illegal;

  assign in_ready_o  = !valid_q || out_ready_i;
  assign out_valid_o = valid_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
      valid_q <= 1'b0;
    else if (in_ready_o)
      valid_q <= in_valid_i;
  end

  always_ff @(posedge clk)
  begin
    if (in_ready_o && in_valid_i)
      pkt_q <= in_data_i;
  end

  for (genvar i = 0; i < FETCH_WIDTH; i++)
  begin : gen_dec
    fe_decoder fe_decoder_i (
      .inst_i   (pkt_q.inst[i]),
      .op_o     (op[i]),
      .illegal_o(illegal[i])
    );
  end

  always_comb
  begin
    out_data_o.mask = pkt_q.mask;
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      out_data_o.slot[i].inst    = pkt_q.inst[i];
      out_data_o.slot[i].op      = op[i];
      out_data_o.slot[i].illegal = illegal[i];
    end
    out_data_o.slot[0].pc = pkt_q.pc;
    out_data_o.slot[1].pc = {pkt_q.pc[XLEN-1:3], 1'b1, pkt_q.pc[1:0]};
  end

endmodule

// ==== hw/fe_pkt_fifo.sv ====
`timescale 1ns/1ps

module fe_pkt_fifo import fe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  fe_dec_pkt_t in_data_i,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output fe_dec_pkt_t out_data_o
);

  fe_dec_pkt_t        mem_q [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr_q;
  logic [FIFO_AW-1:0] rd_ptr_q;
  logic [FIFO_AW:0]   count_q;
  logic               push;
  logic               pop;

  assign in_ready_o  = (count_q != (FIFO_AW + 1)'(FIFO_DEPTH));
  assign out_valid_o = (count_q != '0);
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;
  assign out_data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + (FIFO_AW + 1)'(push) - (FIFO_AW + 1)'(pop);
    end
  end

  // depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk)
  begin
    if (push)
      mem_q[wr_ptr_q] <= in_data_i;
  end

endmodule

// ==== hw/fe_frontend.sv ====
`timescale 1ns/1ps

module fe_frontend import fe_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             redirect_i,
  input  logic [XLEN-1:0]                  redirect_pc_i,
  output logic                             pkg_valid_o,
  input  logic                             pkg_ready_i,
  output logic [FETCH_WIDTH-1:0]           pkg_mask_o,
  output logic [FETCH_WIDTH-1:0][XLEN-1:0] pkg_pc_o,
  output logic [FETCH_WIDTH-1:0][XLEN-1:0] pkg_inst_o,
  output fe_op_e [FETCH_WIDTH-1:0]         pkg_op_o,
  output logic [FETCH_WIDTH-1:0]           pkg_illegal_o
);

  logic                             gen_valid;
  logic                             gen_ready;
  logic [XLEN-1:0]                  gen_pc;
  logic [FETCH_WIDTH-1:0]           gen_mask;
  fe_pc_pkt_t                       gen_pkt;
  logic                             fetch_in_valid;
  logic                             fetch_in_ready;
  fe_pc_pkt_t                       fetch_in;
  logic                             mem_en;
  logic [MEM_ROW_W-1:0]             mem_row;
  logic [FETCH_WIDTH-1:0][XLEN-1:0] mem_data;
  logic                             fetch_out_valid;
  logic                             fetch_out_ready;
  fe_fetch_pkt_t                    fetch_pkt;
  logic                             dec_in_valid;
  logic                             dec_in_ready;
  fe_fetch_pkt_t                    dec_in;
  logic                             dec_out_valid;
  logic                             dec_out_ready;
  fe_dec_pkt_t                      dec_pkt;
  logic                             fifo_in_valid;
  logic                             fifo_in_ready;
  fe_dec_pkt_t                      fifo_in;
  fe_dec_pkt_t                      fifo_out;

  fe_pc_gen fe_pc_gen_i (
    .clk(clk), .rst_n(rst_n), .flush_i(redirect_i), .redirect_pc_i(redirect_pc_i),
    .valid_o(gen_valid), .ready_i(gen_ready), .pc_o(gen_pc), .mask_o(gen_mask)
  );

  assign gen_pkt = '{pc: gen_pc, mask: gen_mask};

  fe_skid_buf #(.T(fe_pc_pkt_t)) skid_a_i (
    .clk(clk), .rst_n(rst_n), .flush_i(redirect_i),
    .in_valid_i(gen_valid), .in_ready_o(gen_ready), .in_data_i(gen_pkt),
    .out_valid_o(fetch_in_valid), .out_ready_i(fetch_in_ready), .out_data_o(fetch_in)
  );

  fe_inst_mem fe_inst_mem_i (
    .clk(clk), .rd_en_i(mem_en), .rd_row_i(mem_row), .rd_data_o(mem_data)
  );

  fe_fetch fe_fetch_i (
    .clk(clk), .rst_n(rst_n), .flush_i(redirect_i),
    .in_valid_i(fetch_in_valid), .in_ready_o(fetch_in_ready),
    .in_pc_i(fetch_in.pc), .in_mask_i(fetch_in.mask),
    .mem_en_o(mem_en), .mem_row_o(mem_row), .mem_data_i(mem_data),
    .out_valid_o(fetch_out_valid), .out_ready_i(fetch_out_ready),
    .out_pc_o(fetch_pkt.pc), .out_inst_o(fetch_pkt.inst), .out_mask_o(fetch_pkt.mask)
  );

  fe_skid_buf #(.T(fe_fetch_pkt_t)) skid_b_i (
    .clk(clk), .rst_n(rst_n), .flush_i(redirect_i),
    .in_valid_i(fetch_out_valid), .in_ready_o(fetch_out_ready), .in_data_i(fetch_pkt),
    .out_valid_o(dec_in_valid), .out_ready_i(dec_in_ready), .out_data_o(dec_in)
  );

  fe_decode_stage fe_decode_stage_i (
    .clk(clk), .rst_n(rst_n), .flush_i(redirect_i),
    .in_valid_i(dec_in_valid), .in_ready_o(dec_in_ready), .in_data_i(dec_in),
    .out_valid_o(dec_out_valid), .out_ready_i(dec_out_ready), .out_data_o(dec_pkt)
  );

  fe_skid_buf #(.T(fe_dec_pkt_t)) skid_c_i (
    .clk(clk), .rst_n(rst_n), .flush_i(redirect_i),
    .in_valid_i(dec_out_valid), .in_ready_o(dec_out_ready), .in_data_i(dec_pkt),
    .out_valid_o(fifo_in_valid), .out_ready_i(fifo_in_ready), .out_data_o(fifo_in)
  );

  fe_pkt_fifo fe_pkt_fifo_i (
    .clk(clk), .rst_n(rst_n), .flush_i(redirect_i),
    .in_valid_i(fifo_in_valid), .in_ready_o(fifo_in_ready), .in_data_i(fifo_in),
    .out_valid_o(pkg_valid_o), .out_ready_i(pkg_ready_i), .out_data_o(fifo_out)
  );

  // per-slot backend ports
  always_comb
  begin
    pkg_mask_o = fifo_out.mask;
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      pkg_pc_o[i]      = fifo_out.slot[i].pc;
      pkg_inst_o[i]    = fifo_out.slot[i].inst;
      pkg_op_o[i]      = fifo_out.slot[i].op;
      pkg_illegal_o[i] = fifo_out.slot[i].illegal;
    end
  end

endmodule

// ==== verification/tb_fe_frontend.sv ====
`timescale 1ns/1ps

module tb_fe_frontend import fe_pkg::*; ();

  localparam int PKT_TIMEOUT = 500;
  localparam int NUM_TESTS   = 7;
  localparam int IMG_WORDS   = MEM_ROWS * FETCH_WIDTH;

  typedef struct packed {
    logic [XLEN-1:0]        target;
    int                     count;
    int                     stall_pct;
    int                     hold;
    logic [FETCH_WIDTH-1:0] first_mask;
  } test_entry_t;

  logic                             clk;
  logic                             rst_n;
  logic                             redirect_i;
  logic [XLEN-1:0]                  redirect_pc_i;
  logic                             pkg_valid_o;
  logic                             pkg_ready_i;
  logic [FETCH_WIDTH-1:0]           pkg_mask_o;
  logic [FETCH_WIDTH-1:0][XLEN-1:0] pkg_pc_o;
  logic [FETCH_WIDTH-1:0][XLEN-1:0] pkg_inst_o;
  fe_op_e [FETCH_WIDTH-1:0]         pkg_op_o;
  logic [FETCH_WIDTH-1:0]           pkg_illegal_o;

  logic [XLEN-1:0] image [IMG_WORDS];
  // next block the backend should see
  logic [XLEN-1:0] walk_pc;

  // target, packets, back-pressure %, stall cycles, first mask
  test_entry_t tests [NUM_TESTS] = '{
    '{32'h0000_0014, 10,  0,  0, 2'b01},
    '{32'h0000_0040, 24, 30,  0, 2'b11},
    '{32'h0000_0074, 30, 50, 40, 2'b01},
    '{32'h0000_002e, 12, 70,  0, 2'b01},
    '{32'h0000_007b, 20,  0, 25, 2'b11},
    '{32'h0000_0104, 18, 85,  0, 2'b01},
    '{32'h0000_0040, 24,  0,  0, 2'b11}
  };

  fe_frontend fe_frontend_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .pkg_valid_o  (pkg_valid_o),
    .pkg_ready_i  (pkg_ready_i),
    .pkg_mask_o   (pkg_mask_o),
    .pkg_pc_o     (pkg_pc_o),
    .pkg_inst_o   (pkg_inst_o),
    .pkg_op_o     (pkg_op_o),
    .pkg_illegal_o(pkg_illegal_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("SIMULATION FAILED");
    $fatal(1, "testbench stopped at %0t", $time);
  endtask

  task automatic check_pc(input string name, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_inst(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_op(input string name, input fe_op_e got, input fe_op_e exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_illegal(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_mask(input string name, input logic [FETCH_WIDTH-1:0] got,
                            input logic [FETCH_WIDTH-1:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_valid(input logic exp);
    if (pkg_valid_o !== exp)
    begin
      $display("[ERROR] pkg_valid_o got 0x%h expected 0x%h", pkg_valid_o, exp);
      stop_on_error();
    end
  endtask

  // rv32i opcode map, inst[6:2] with inst[1:0] == 11
  function automatic fe_op_e classify_opcode(input logic [XLEN-1:0] inst);
    fe_op_e op;
    op = OP_NONE;
    if (inst[1:0] == 2'b11)
    begin
      case (inst[6:2])
        5'b01100, 5'b00100, 5'b01101, 5'b00101:
          op = OP_ALU;
        5'b00000:
          op = OP_LOAD;
        5'b01000:
          op = OP_STORE;
        5'b11000, 5'b11001, 5'b11011:
          op = OP_BRANCH;
        5'b11100:
          op = OP_SYSTEM;
        default:
          op = OP_NONE;
      endcase
    end
    return op;
  endfunction

  task automatic predict_packet(output logic [FETCH_WIDTH-1:0] mask,
                                output logic [FETCH_WIDTH-1:0][XLEN-1:0] pc,
                                output logic [FETCH_WIDTH-1:0][XLEN-1:0] inst);
    int idx;
    idx     = int'((walk_pc >> 2) % IMG_WORDS);
    pc      = '0;
    inst    = '0;
    pc[0]   = walk_pc;
    inst[0] = image[idx];
    if (walk_pc[2])
    begin
      // entered mid-block, upper word moves to slot 0
      mask = 2'b01;
    end
    else
    begin
      mask    = 2'b11;
      pc[1]   = walk_pc + 32'd4;
      inst[1] = image[idx + 1];
    end
    walk_pc = {walk_pc[XLEN-1:3], 3'b000} + 32'd8;
  endtask

  task automatic compare_packet();
    logic [FETCH_WIDTH-1:0]           exp_mask;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] exp_pc;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] exp_inst;
    fe_op_e                           exp_op;
    predict_packet(exp_mask, exp_pc, exp_inst);
    check_mask("pkg_mask_o", pkg_mask_o, exp_mask);
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      if (exp_mask[i])
      begin
        exp_op = classify_opcode(exp_inst[i]);
        check_pc($sformatf("pkg_pc_o[%0d]", i), pkg_pc_o[i], exp_pc[i]);
        check_inst($sformatf("pkg_inst_o[%0d]", i), pkg_inst_o[i], exp_inst[i]);
        check_op($sformatf("pkg_op_o[%0d]", i), pkg_op_o[i], exp_op);
        check_illegal($sformatf("pkg_illegal_o[%0d]", i), pkg_illegal_o[i],
                      exp_op == OP_NONE);
      end
    end
  endtask

  // outputs are registered, so valid and data are stable at the falling edge
  task automatic collect_packets(input int count, input int stall_pct,
                                 input logic [FETCH_WIDTH-1:0] first_mask);
    int   got;
    int   waited;
    logic take;
    got = 0;
    while (got < count)
    begin
      waited = 0;
      take   = 1'b0;
      while (!take)
      begin
        @(negedge clk);
        pkg_ready_i = ($urandom_range(99) >= stall_pct);
        take        = pkg_valid_o && pkg_ready_i;
        waited++;
        if (!take && waited > PKT_TIMEOUT)
        begin
          $display("no packet arrived on pkg_valid_o within %0d cycles", PKT_TIMEOUT);
          stop_on_error();
        end
      end
      if (got == 0)
        check_mask("pkg_mask_o", pkg_mask_o, first_mask);
      compare_packet();
      got++;
    end
  endtask

  task automatic apply_redirect(input logic [XLEN-1:0] target);
    @(negedge clk);
    pkg_ready_i   = 1'b0;
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    @(negedge clk);
    redirect_i = 1'b0;
    // everything in flight is gone one cycle later
    check_valid(1'b0);
    walk_pc = {target[XLEN-1:2], 2'b00};
  endtask

  initial
  begin
    void'($urandom(32'ha8a3_268f));
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    pkg_ready_i   = 1'b0;
    walk_pc       = '0;
    $readmemh("hw/program.hex", image);

    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_valid(1'b0);

    // from pc 0 past the end of the image
    collect_packets(20, 0, 2'b11);

    for (int t = 0; t < NUM_TESTS; t++)
    begin
      apply_redirect(tests[t].target);
      repeat (tests[t].hold) @(negedge clk);
      collect_packets(tests[t].count, tests[t].stall_pct, tests[t].first_mask);
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== compile.f ====
hw/fe_pkg.sv
hw/fe_skid_buf.sv
hw/fe_pc_gen.sv
hw/fe_inst_mem.sv
hw/fe_fetch.sv
hw/fe_decoder.sv
hw/fe_decode_stage.sv
hw/fe_pkt_fifo.sv
hw/fe_frontend.sv
verification/tb_fe_frontend.sv

// ==== hw/program.hex ====
// one 32-bit instruction word per line, word addresses 0 to 31 in order
00000013
00a00093
000122b7
00001317
0000a383
00112423
00208463
008000ef
000080e7
00000073
002081b3
00004501
0000000b
00b12023
40208233
00100073
ffffffff
00000000
0041a283
00c0006f
fe209ee3
0000000f
00412603
00c2a023
12345637
00000297
0000fffe
30200073
0062e3b3
0000002f
00000067
0ff00513
